/* include/fxp_defs_defs.svh */
// Word format shared by the unit; the divider runs FXP_WIDTH-1+FXP_FRACBITS iterations
`ifndef FXP_DEFS_DEFS_SVH
`define FXP_DEFS_DEFS_SVH

// Signed word width including the sign bit
`define FXP_WIDTH 18

// Fraction bits of the Q format (below FXP_WIDTH-1)
`define FXP_FRACBITS 12

// Register map address width
`define FXP_ADDR_W 3

`endif

/* source/fxp_types_pkg.sv */
// Data structs between the register block and the divider; widths follow the defs header
`include "fxp_defs_defs.svh"

package fxp_types_pkg;

    // Operands as written by software
    typedef struct packed {
        logic signed [`FXP_WIDTH-1:0] dividend;  // Top
        logic signed [`FXP_WIDTH-1:0] divisor;   // Bottom
    } fxp_operands_t;

    // Divider outcome held until the next start
    typedef struct packed {
        logic signed [`FXP_WIDTH-1:0] quotient;
        logic                         dbz;       // Divide by zero
        logic                         ovf;       // Result out of range
        logic                         valid;     // Quotient usable
    } fxp_result_t;

endpackage

/* source/fxp_regmap_pkg.sv */
// Register map and FSM encodings; addresses above REG_COUNT read as zero
`include "fxp_defs_defs.svh"

package fxp_regmap_pkg;

    // Word addresses on the register bus
    typedef enum logic [`FXP_ADDR_W-1:0] {
        REG_A      = 0,
        REG_B      = 1,
        REG_CTRL   = 2,
        REG_STATUS = 3,
        REG_RESULT = 4,
        REG_COUNT  = 5
    } fxp_reg_addr_t;

    // CTRL layout with start in bit 0
    typedef struct packed {
        logic irq_en;
        logic start;    // Write only, reads back zero
    } fxp_ctrl_t;

    // STATUS layout with busy in bit 0
    typedef struct packed {
        logic ovf;
        logic dbz;
        logic valid;
        logic done_sticky;
        logic busy;
    } fxp_status_t;

    // Divider FSM
    typedef enum logic [2:0] {
        IDLE,
        INIT,
        CALC,
        ROUND,
        SIGN
    } fxp_div_state_t;

endpackage

/* source/fixed_point_divide.sv */
// One division at a time; operands are sampled only in the start cycle and rounding is half to even
`timescale 1ns/1ps
`include "fxp_defs_defs.svh"

module fixed_point_divide (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        start,
    input  fxp_types_pkg::fxp_operands_t operands,
    output logic                        busy,
    output logic                        done,
    output fxp_types_pkg::fxp_result_t  result
);

    localparam int unsigned W    = `FXP_WIDTH;
    localparam int unsigned UW   = W - 1;          // Magnitude width
    localparam int unsigned FB   = `FXP_FRACBITS;
    localparam int unsigned ITER = UW + FB;        // One quotient bit each
    localparam int unsigned CW   = $clog2(ITER) + 1;

    localparam logic [W-1:0]  MOST_NEG  = {1'b1, {UW{1'b0}}};
    localparam logic [CW-1:0] LAST_INT  = CW'(UW - 1);   // Last integer bit
    localparam logic [CW-1:0] LAST_ITER = CW'(ITER - 1);

    fxp_regmap_pkg::fxp_div_state_t state;

    logic [CW-1:0] i;
    logic          sign_diff;
    logic [UW-1:0] a_u, b_u;
    logic [UW-1:0] quo, quo_next;
    logic [UW:0]   acc, acc_next, acc_diff;
    logic          late_ovf;
    logic          round_up;

    // Restoring shift-subtract step
    always_comb begin
        acc_diff = acc - {1'b0, b_u};
        if (acc >= {1'b0, b_u}) begin
            {acc_next, quo_next} = {acc_diff[UW-1:0], quo, 1'b1};
        end else begin
            {acc_next, quo_next} = {acc, quo} << 1;
        end
    end

    // Integer bits beyond the Q format would be lost
    assign late_ovf = (i == LAST_INT) && (quo_next[UW-1:UW-FB] != '0);

    // Guard bit set, then odd LSB or nonzero remainder
    assign round_up = quo_next[0] && (quo[0] || (acc_next[UW:1] != '0));

    // Operand magnitudes and shift register
    always_ff @(posedge clk) begin
        case (state)
            fxp_regmap_pkg::IDLE: begin
                if (start) begin
                    a_u <= operands.dividend[W-1] ? -operands.dividend[UW-1:0]
                                                  : operands.dividend[UW-1:0];
                    b_u <= operands.divisor[W-1] ? -operands.divisor[UW-1:0]
                                                 : operands.divisor[UW-1:0];
                    sign_diff <= operands.dividend[W-1] ^ operands.divisor[W-1];
                end
            end
            fxp_regmap_pkg::INIT: begin
                {acc, quo} <= {{UW{1'b0}}, a_u, 1'b0};
            end
            fxp_regmap_pkg::CALC: begin
                if (!late_ovf) begin
                    acc <= acc_next;
                    quo <= quo_next;
                end
            end
            fxp_regmap_pkg::ROUND: begin
                if (round_up) begin
                    quo <= quo + 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    // Control FSM and result flags
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state  <= fxp_regmap_pkg::IDLE;
            i      <= '0;
            busy   <= 1'b0;
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                fxp_regmap_pkg::IDLE: begin
                    if (start) begin
                        result <= '0;
                        if (operands.divisor == '0) begin
                            done       <= 1'b1;   // Answer without iterating
                            result.dbz <= 1'b1;
                        end else if (operands.dividend == MOST_NEG ||
                                     operands.divisor == MOST_NEG) begin
                            done       <= 1'b1;
                            result.ovf <= 1'b1;
                        end else begin
                            state <= fxp_regmap_pkg::INIT;
                            busy  <= 1'b1;
                        end
                    end
                end
                fxp_regmap_pkg::INIT: begin
                    state <= fxp_regmap_pkg::CALC;
                    i     <= '0;
                end
                fxp_regmap_pkg::CALC: begin
                    if (late_ovf) begin
                        state      <= fxp_regmap_pkg::IDLE;
                        busy       <= 1'b0;
                        done       <= 1'b1;
                        result.ovf <= 1'b1;
                    end else begin
                        if (i == LAST_ITER) begin
                            state <= fxp_regmap_pkg::ROUND;
                        end
                        i <= i + 1'b1;
                    end
                end
                fxp_regmap_pkg::ROUND: begin
                    state <= fxp_regmap_pkg::SIGN;
                end
                fxp_regmap_pkg::SIGN: begin
                    state <= fxp_regmap_pkg::IDLE;
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    result.valid <= 1'b1;
                    // Zero magnitude never becomes negative zero
                    if (quo == '0) begin
                        result.quotient <= '0;
                    end else begin
                        result.quotient <= sign_diff ? {1'b1, -quo} : {1'b0, quo};
                    end
                end
                default: begin
                    state <= fxp_regmap_pkg::IDLE;
                    busy  <= 1'b0;
                end
            endcase
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rstn)
        done |=> !done);

    a_busy_done_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(busy && done));

    a_flags_excl: assert property (@(posedge clk) disable iff (!rstn)
        done |-> !(result.dbz && result.ovf));

endmodule

/* source/fxp_divide_regs.sv */
// Plain strobe bus with no wait states; reads return one cycle after rd_en, starts while busy are dropped
`timescale 1ns/1ps
`include "fxp_defs_defs.svh"

module fxp_divide_regs (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          wr_en,
    input  logic                          rd_en,
    input  logic [`FXP_ADDR_W-1:0]        addr,
    input  logic [`FXP_WIDTH-1:0]         wdata,
    output logic [`FXP_WIDTH-1:0]         rdata,
    output logic                          irq,
    output fxp_types_pkg::fxp_operands_t  operands,
    output logic                          start,
    input  logic                          busy,
    input  logic                          done,
    input  fxp_types_pkg::fxp_result_t    result
);

    localparam int unsigned W        = `FXP_WIDTH;
    localparam int unsigned COUNT_W  = 16;
    localparam int unsigned CTRL_PAD = W - $bits(fxp_regmap_pkg::fxp_ctrl_t);
    localparam int unsigned STAT_PAD = W - $bits(fxp_regmap_pkg::fxp_status_t);

    fxp_regmap_pkg::fxp_reg_addr_t reg_addr;
    fxp_regmap_pkg::fxp_ctrl_t     ctrl_wr, ctrl_rd;
    fxp_regmap_pkg::fxp_status_t   status_rd;

    logic               irq_en;
    logic               done_sticky;
    logic               res_valid, res_dbz, res_ovf;
    logic [W-1:0]       res_quotient;
    logic [COUNT_W-1:0] count;

    assign reg_addr = fxp_regmap_pkg::fxp_reg_addr_t'(addr);
    assign ctrl_wr  = fxp_regmap_pkg::fxp_ctrl_t'(wdata[1:0]);

    always_comb begin
        ctrl_rd.irq_en        = irq_en;
        ctrl_rd.start         = 1'b0;     // Self-clearing
        status_rd.busy        = busy;     // Live from the divider
        status_rd.done_sticky = done_sticky;
        status_rd.valid       = res_valid;
        status_rd.dbz         = res_dbz;
        status_rd.ovf         = res_ovf;
    end

    assign irq = done_sticky && irq_en;

    // Register writes and completion capture
    always_ff @(posedge clk) begin
        if (!rstn) begin
            operands     <= '0;
            irq_en       <= 1'b0;
            start        <= 1'b0;
            done_sticky  <= 1'b0;
            res_quotient <= '0;
            res_valid    <= 1'b0;
            res_dbz      <= 1'b0;
            res_ovf      <= 1'b0;
            count        <= '0;
        end else begin
            start <= 1'b0;
            if (wr_en) begin
                case (reg_addr)
                    fxp_regmap_pkg::REG_A:      operands.dividend <= wdata;
                    fxp_regmap_pkg::REG_B:      operands.divisor  <= wdata;
                    fxp_regmap_pkg::REG_CTRL: begin
                        irq_en <= ctrl_wr.irq_en;
                        // Divider picks up start next edge, so block a back-to-back one
                        start  <= ctrl_wr.start && !busy && !start;
                    end
                    fxp_regmap_pkg::REG_STATUS: done_sticky <= 1'b0;  // Any value clears
                    default: begin
                    end
                endcase
            end
            if (done) begin
                done_sticky  <= 1'b1;      // Wins over a same-cycle clear
                res_quotient <= result.quotient;
                res_valid    <= result.valid;
                res_dbz      <= result.dbz;
                res_ovf      <= result.ovf;
                count        <= count + 1'b1;
            end
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rdata <= '0;
        end else if (rd_en) begin
            case (reg_addr)
                fxp_regmap_pkg::REG_A:      rdata <= operands.dividend;
                fxp_regmap_pkg::REG_B:      rdata <= operands.divisor;
                fxp_regmap_pkg::REG_CTRL:   rdata <= {{CTRL_PAD{1'b0}}, ctrl_rd};
                fxp_regmap_pkg::REG_STATUS: rdata <= {{STAT_PAD{1'b0}}, status_rd};
                fxp_regmap_pkg::REG_RESULT: rdata <= res_quotient;
                fxp_regmap_pkg::REG_COUNT:  rdata <= {{(W - COUNT_W){1'b0}}, count};
                default:                    rdata <= '0;
            endcase
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!rstn)
        start |-> !busy);

    // The single start pulse is taken by the divider on the next edge
    a_start_taken: assert property (@(posedge clk) disable iff (!rstn)
        start |=> busy || done);

endmodule

/* source/fxp_divide_top.sv */
// Single divider behind the register block; no bus protocol beyond read and write strobes
`timescale 1ns/1ps
`include "fxp_defs_defs.svh"

module fxp_divide_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   wr_en,
    input  logic                   rd_en,
    input  logic [`FXP_ADDR_W-1:0] addr,
    input  logic [`FXP_WIDTH-1:0]  wdata,
    output logic [`FXP_WIDTH-1:0]  rdata,
    output logic                   irq
);

    fxp_types_pkg::fxp_operands_t operands;
    fxp_types_pkg::fxp_result_t   result;
    logic                         start;
    logic                         busy;
    logic                         done;

    fxp_divide_regs u_regs (
        .clk      (clk),
        .rstn     (rstn),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .irq      (irq),
        .operands (operands),
        .start    (start),
        .busy     (busy),
        .done     (done),
        .result   (result)
    );

    fixed_point_divide u_div (
        .clk      (clk),
        .rstn     (rstn),
        .start    (start),
        .operands (operands),
        .busy     (busy),
        .done     (done),
        .result   (result)
    );

endmodule

/* verif/fxp_divide_tb.sv */
// Self-checking testbench; fixed random seed, stops at the first mismatch, run length capped in cycles
`timescale 1ns/1ps
`include "fxp_defs_defs.svh"

module fxp_divide_tb;

    localparam int W           = `FXP_WIDTH;
    localparam int FB          = `FXP_FRACBITS;
    localparam int CYCLE_LIMIT = 80 * 40 + 500;   // Divisions times worst case, plus margin
    localparam logic signed [W-1:0] MOST_NEG = {1'b1, {(W-1){1'b0}}};

    logic                   clk;
    logic                   rstn;
    logic                   wr_en;
    logic                   rd_en;
    logic [`FXP_ADDR_W-1:0] addr;
    logic [W-1:0]           wdata;
    logic [W-1:0]           rdata;
    logic                   irq;

    logic irq_en_seen;      // irq_en as last written
    int   cycles = 0;
    int   accepted;
    int   full_runs = 0;

    fxp_divide_top u_dut (
        .clk   (clk),
        .rstn  (rstn),
        .wr_en (wr_en),
        .rd_en (rd_en),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .irq   (irq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [W-1:0] exp,
                               input logic [W-1:0] got);
        assert (got == exp) else begin
            fail_run($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, exp, got));
        end
    endtask

    // Run limit, and how many divisions went all the way through the sign step
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (u_dut.u_div.state == fxp_regmap_pkg::SIGN) full_runs <= full_runs + 1;
        if (cycles >= CYCLE_LIMIT) fail_run($sformatf("Timeout after %0d cycles", cycles));
    end

    a_irq_off: assert property (@(posedge clk) disable iff (!rstn) !irq_en_seen |-> !irq)
        else fail_run("FAILED irq: expected 0x0, got 0x1");

    // A STATUS write drops irq on the next edge
    a_irq_clear: assert property (@(posedge clk) disable iff (!rstn)
        (wr_en && addr == fxp_regmap_pkg::REG_STATUS) |=> !irq)
        else fail_run("FAILED irq: expected 0x0, got 0x1");

    task automatic write_reg(input fxp_regmap_pkg::fxp_reg_addr_t a, input logic [W-1:0] d);
        wr_en = 1'b1;
        addr  = a;
        wdata = d;
        @(posedge clk);
        #10;
        wr_en = 1'b0;
    endtask

    task automatic read_reg(input fxp_regmap_pkg::fxp_reg_addr_t a, output logic [W-1:0] d);
        rd_en = 1'b1;
        addr  = a;
        @(posedge clk);
        #10;
        rd_en = 1'b0;
        d     = rdata;          // Valid one cycle after rd_en
    endtask

    // Poll STATUS until done_sticky is set
    task automatic wait_done();
        logic [W-1:0] st;
        st = '0;
        while (!st[1]) read_reg(fxp_regmap_pkg::REG_STATUS, st);
    endtask

    // Expected quotient and {ovf, dbz, valid}, rounded half to even
    function automatic void model_div(input logic signed [W-1:0] a,
                                      input logic signed [W-1:0] b,
                                      output logic [W-1:0] q, output logic [2:0] flags);
        longint       ma, mb, num, qt, rem;
        logic [W-2:0] mag;
        q     = '0;
        flags = 3'b000;
        ma    = (a < 0) ? -longint'(a) : longint'(a);
        mb    = (b < 0) ? -longint'(b) : longint'(b);
        if (b == 0) begin
            flags = 3'b010;     // dbz wins
        end else if (a == MOST_NEG || b == MOST_NEG) begin
            flags = 3'b100;
        end else begin
            num = ma <<< FB;
            qt  = num / mb;
            rem = num % mb;
            if (qt >= (longint'(1) << (W - 1))) begin
                flags = 3'b100;
            end else begin
                if (2 * rem > mb || (2 * rem == mb && qt[0])) qt = qt + 1;
                flags = 3'b001;
                mag   = qt[W-2:0];
                if (mag != '0) q = (a[W-1] ^ b[W-1]) ? -{1'b0, mag} : {1'b0, mag};
            end
        end
    endfunction

    task automatic run_division(input logic signed [W-1:0] a, input logic signed [W-1:0] b,
                                input logic irq_on);
        logic [W-1:0] q_exp;
        logic [2:0]   f_exp;
        logic [W-1:0] st;
        logic [W-1:0] res;
        model_div(a, b, q_exp, f_exp);
        write_reg(fxp_regmap_pkg::REG_STATUS, '0);
        write_reg(fxp_regmap_pkg::REG_A, a);
        write_reg(fxp_regmap_pkg::REG_B, b);
        write_reg(fxp_regmap_pkg::REG_CTRL, {{(W-2){1'b0}}, irq_on, 1'b1});
        irq_en_seen = irq_on;
        accepted++;
        wait_done();
        read_reg(fxp_regmap_pkg::REG_STATUS, st);
        read_reg(fxp_regmap_pkg::REG_RESULT, res);
        check_value("STATUS.ovf_dbz_valid", W'(f_exp), W'(st[4:2]));
        check_value("RESULT", q_exp, res);
        check_value("irq", W'(irq_on), W'(irq));
    endtask

    // Second start lands while busy and must be dropped
    task automatic start_while_busy();
        logic [W-1:0] q_exp;
        logic [2:0]   f_exp;
        logic [W-1:0] st;
        logic [W-1:0] res;
        logic [W-1:0] cnt_before;
        logic [W-1:0] cnt_after;
        model_div(18'sh01000, 18'sh00c00, q_exp, f_exp);
        read_reg(fxp_regmap_pkg::REG_COUNT, cnt_before);
        check_value("COUNT", W'(accepted), cnt_before);
        write_reg(fxp_regmap_pkg::REG_STATUS, '0);
        write_reg(fxp_regmap_pkg::REG_A, 18'sh01000);
        write_reg(fxp_regmap_pkg::REG_B, 18'sh00c00);
        write_reg(fxp_regmap_pkg::REG_CTRL, W'(1));
        irq_en_seen = 1'b0;
        accepted++;
        st = '0;
        while (!st[0]) read_reg(fxp_regmap_pkg::REG_STATUS, st);
        write_reg(fxp_regmap_pkg::REG_A, -18'sh02000);
        write_reg(fxp_regmap_pkg::REG_B, 18'sh00400);
        write_reg(fxp_regmap_pkg::REG_CTRL, W'(1));
        wait_done();
        read_reg(fxp_regmap_pkg::REG_STATUS, st);
        check_value("STATUS.busy", '0, W'(st[0]));
        read_reg(fxp_regmap_pkg::REG_RESULT, res);
        check_value("RESULT", q_exp, res);
        read_reg(fxp_regmap_pkg::REG_COUNT, cnt_after);
        check_value("COUNT", W'(accepted), cnt_after);
    endtask

    initial begin
        logic signed [W-1:0] a;
        logic signed [W-1:0] b;
        logic [W-1:0]        val;
        void'($urandom(32'h6f94_23b8));
        rstn        = 1'b0;
        wr_en       = 1'b0;
        rd_en       = 1'b0;
        addr        = '0;
        wdata       = '0;
        irq_en_seen = 1'b0;
        accepted    = 0;
        repeat (5) @(posedge clk);
        #10;
        rstn = 1'b1;
        check_value("rdata", '0, rdata);
        check_value("irq", '0, W'(irq));
        read_reg(fxp_regmap_pkg::REG_STATUS, val);
        check_value("STATUS", '0, val);
        read_reg(fxp_regmap_pkg::REG_COUNT, val);
        check_value("COUNT", '0, val);

        run_division(18'sh01800, 18'sh00800, 1'b1);     // 1.5 / 0.5
        run_division(-18'sh03000, 18'sh02000, 1'b0);    // -3 / 2
        run_division(18'sd1, 18'sh02000, 1'b1);         // Ties at 0.5, 1.5, 2.5, -1.5 LSB
        run_division(18'sd3, 18'sh02000, 1'b0);
        run_division(18'sd5, 18'sh02000, 1'b0);
        run_division(-18'sd3, 18'sh02000, 1'b1);

        run_division(18'sh01000, '0, 1'b1);
        run_division(MOST_NEG, 18'sh01000, 1'b0);
        run_division(18'sh01000, MOST_NEG, 1'b0);
        run_division(18'sh1ffff, 18'sd1, 1'b1);         // Late overflow in CALC

        start_while_busy();

        for (int k = 0; k < 60; k++) begin
            a = W'($urandom);
            b = W'($urandom);
            if (k % 3 == 0) a = a >>> 6;                // Keep many quotients in range
            run_division(a, b, k[0]);
        end

        write_reg(fxp_regmap_pkg::REG_STATUS, '0);
        check_value("irq", '0, W'(irq));
        read_reg(fxp_regmap_pkg::REG_COUNT, val);
        check_value("COUNT", W'(accepted), val);
        $display("Divisions through SIGN: %0d of %0d", full_runs, accepted);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* files.f */
+incdir+include
source/fxp_types_pkg.sv
source/fxp_regmap_pkg.sv
source/fixed_point_divide.sv
source/fxp_divide_regs.sv
source/fxp_divide_top.sv
verif/fxp_divide_tb.sv

/* run.sh */
#!/bin/sh
# Builds and runs the divider testbench; a failed check ends in $fatal and a nonzero status
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f files.f \
    --top-module fxp_divide_tb \
    -o fxp_divide_sim

./obj_dir/fxp_divide_sim
